// ==== source/map_pkg.sv ====
// Obstacle map shared definitions
`default_nettype none

package map_pkg;

    // ==========================================================
    // Screen geometry
    // ==========================================================
    localparam int screen_width = 640;
    localparam int upper_bound  = 20;
    localparam int lower_bound  = 460;

    // Obstacle size and spacing limits
    localparam int min_width  = 20;
    localparam int max_width  = 80;
    localparam int min_height = 20;
    localparam int max_height = 150;
    localparam int min_gap    = 80;
    localparam int max_gap    = 180;

    // Boundary bands and band selection (102 of 256, roughly 40 %)
    localparam int zone_size          = 60;
    localparam int boundary_threshold = 102;

    // Slot is freed once its right edge is left of this line
    localparam int delete_boundary = -100;

    localparam int score_max = 9999;

    // Off-screen sentinels for invisible slots
    localparam int hidden_x = 700;
    localparam int hidden_y = 500;

    // ==========================================================
    // Types
    // ==========================================================
    typedef logic signed [11:0] pos_x_t;
    typedef logic [9:0]         screen_x_t;
    typedef logic [8:0]         screen_y_t;
    typedef logic [7:0]         size_t;
    typedef logic [13:0]        score_t;

    // Both pause codes hold the map
    typedef enum logic [1:0] {
        mode_idle    = 2'd0,
        mode_run     = 2'd1,
        mode_pause_a = 2'd2,
        mode_pause_b = 2'd3
    } game_mode_e;

endpackage

`default_nettype wire

// ==== source/obstacle_rng.sv ====
// Obstacle parameter generator
`default_nettype none
`timescale 1ns/1ps

module obstacle_rng (
    input  wire               clk,
    input  wire               rst_n,
    output map_pkg::size_t    new_width,
    output map_pkg::size_t    new_height,
    output map_pkg::size_t    new_gap,
    output map_pkg::screen_y_t new_y
);

    localparam int width_span  = map_pkg::max_width - map_pkg::min_width + 1;
    localparam int height_span = map_pkg::max_height - map_pkg::min_height + 1;
    localparam int gap_span    = map_pkg::max_gap - map_pkg::min_gap + 1;
    localparam int mid_lo      = map_pkg::upper_bound + map_pkg::zone_size;

    logic [31:0] lfsr;
    logic [7:0]  width_mix;
    logic [7:0]  height_mix;
    logic [7:0]  gap_mix;
    logic [8:0]  max_y;
    logic [8:0]  mid_hi;
    logic [8:0]  y_pick;
    logic        pick_boundary;

    // Fibonacci LFSR, taps 32 22 2 1
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 32'h1234_5678;
        end else begin
            lfsr <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        end
    end

    // ==========================================================
    // Size and gap from mixed byte pairs
    // ==========================================================
    assign width_mix  = lfsr[7:0] ^ lfsr[15:8];
    assign height_mix = lfsr[23:16] ^ lfsr[31:24];
    assign gap_mix    = lfsr[31:24] ^ lfsr[7:0];

    assign new_width  = map_pkg::size_t'(map_pkg::min_width + int'(width_mix) % width_span);
    assign new_height = map_pkg::size_t'(map_pkg::min_height + int'(height_mix) % height_span);
    assign new_gap    = map_pkg::size_t'(map_pkg::min_gap + int'(gap_mix) % gap_span);

    // ==========================================================
    // Vertical placement
    // ==========================================================
    always_comb begin
        // Lowest top edge that keeps the obstacle inside the play area
        max_y  = 9'(map_pkg::lower_bound - int'(new_height));
        mid_hi = max_y - 9'(map_pkg::zone_size);
        pick_boundary = int'(lfsr[7:0]) < map_pkg::boundary_threshold;

        if (pick_boundary) begin
            if (lfsr[8]) begin
                y_pick = 9'(map_pkg::upper_bound) + 9'(lfsr[23:16] % 8'(map_pkg::zone_size));
            end else begin
                y_pick = max_y - 9'(lfsr[15:8] % 8'(map_pkg::zone_size));
            end
        end else begin
            // Middle band is never empty with the given height limit
            y_pick = 9'(mid_lo) + (9'(lfsr[31:24] ^ lfsr[15:8]) % (mid_hi - 9'(mid_lo)));
        end

        if (y_pick > max_y) begin
            y_pick = max_y;
        end
        if (y_pick < 9'(map_pkg::upper_bound)) begin
            y_pick = 9'(map_pkg::upper_bound);
        end
        new_y = y_pick;
    end

    a_width_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (int'(new_width) >= map_pkg::min_width) && (int'(new_width) <= map_pkg::max_width)
    );

endmodule

`default_nettype wire

// ==== source/run_ctrl.sv ====
// Game mode and scroll control
`default_nettype none
`timescale 1ns/1ps

module run_ctrl #(
    parameter int scroll_speed = 4
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  map_pkg::game_mode_e gamemode,
    input  map_pkg::size_t      new_gap,
    input  wire                 spawn_done,
    input  map_pkg::score_t     removed_count,
    output logic                run,
    output logic                clear,
    output logic                spawn_req,
    output map_pkg::score_t     score,
    output map_pkg::screen_x_t  displacement
);

    localparam map_pkg::pos_x_t spawn_init =
        map_pkg::pos_x_t'(map_pkg::screen_width + map_pkg::min_gap);

    map_pkg::game_mode_e prev_mode;
    map_pkg::pos_x_t     spawn_cnt;
    logic [14:0]         score_sum;

    // ==========================================================
    // Mode decoding
    // ==========================================================
    assign run   = (gamemode == map_pkg::mode_run);
    // Restart on the first run cycle after idle
    assign clear = (gamemode == map_pkg::mode_idle) ||
                   (run && (prev_mode == map_pkg::mode_idle));

    // Countdown reaching the screen edge asks for a new obstacle
    assign spawn_req = run && (spawn_cnt <= map_pkg::pos_x_t'(map_pkg::screen_width));

    assign score_sum = {1'b0, score} + 15'(removed_count);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prev_mode    <= map_pkg::mode_idle;
            spawn_cnt    <= spawn_init;
            score        <= '0;
            displacement <= '0;
        end else begin
            prev_mode <= gamemode;

            if (gamemode == map_pkg::mode_idle) begin
                displacement <= '0;
            end else if (run) begin
                displacement <= displacement - map_pkg::screen_x_t'(scroll_speed);
            end

            if (clear) begin
                spawn_cnt <= spawn_init;
                score     <= '0;
            end else if (run) begin
                // No free slot keeps the countdown falling and the request up
                if (spawn_done) begin
                    spawn_cnt <= map_pkg::pos_x_t'(map_pkg::screen_width + int'(new_gap));
                end else begin
                    spawn_cnt <= spawn_cnt - map_pkg::pos_x_t'(scroll_speed);
                end

                if (int'(score_sum) > map_pkg::score_max) begin
                    score <= map_pkg::score_t'(map_pkg::score_max);
                end else begin
                    score <= score_sum[13:0];
                end
            end
        end
    end

    a_score_sat: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(score) <= map_pkg::score_max
    );

endmodule

`default_nettype wire

// ==== source/obstacle_field.sv ====
// Obstacle slot storage and scrolling
`default_nettype none
`timescale 1ns/1ps

module obstacle_field #(
    parameter int num_obstacles = 10,
    parameter int scroll_speed  = 4
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        run,
    input  wire                                        clear,
    input  wire                                        spawn_req,
    input  map_pkg::size_t                             new_width,
    input  map_pkg::size_t                             new_height,
    input  map_pkg::screen_y_t                         new_y,
    output logic                                       spawn_done,
    output map_pkg::score_t                            removed_count,
    output logic [num_obstacles-1:0]                   slot_active,
    output map_pkg::pos_x_t   [num_obstacles-1:0]      slot_x,
    output map_pkg::screen_y_t [num_obstacles-1:0]     slot_y,
    output map_pkg::size_t    [num_obstacles-1:0]      slot_w,
    output map_pkg::size_t    [num_obstacles-1:0]      slot_h
);

    localparam int idx_w = (num_obstacles > 1) ? $clog2(num_obstacles) : 1;

    map_pkg::pos_x_t          right_edge [num_obstacles];
    logic [num_obstacles-1:0] expired;
    logic [idx_w-1:0]         free_idx;
    logic                     free_found;
    map_pkg::score_t          del_cnt;
    logic                     step;

    assign step = run && !clear;

    // ==========================================================
    // Removal detection
    // ==========================================================
    always_comb begin
        del_cnt = '0;
        for (int i = 0; i < num_obstacles; i++) begin
            right_edge[i] = slot_x[i] + map_pkg::pos_x_t'(slot_w[i]);
            expired[i]    = slot_active[i] &&
                            (right_edge[i] < map_pkg::pos_x_t'(map_pkg::delete_boundary));
            if (expired[i]) begin
                del_cnt = del_cnt + 1'b1;
            end
        end
    end

    assign removed_count = step ? del_cnt : '0;

    // Lowest inactive slot takes the next obstacle
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < num_obstacles; i++) begin
            if (!slot_active[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = idx_w'(i);
            end
        end
    end

    assign spawn_done = spawn_req && step && free_found;

    // ==========================================================
    // Slot state
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_active <= '0;
        end else if (clear) begin
            slot_active <= '0;
        end else if (run) begin
            for (int i = 0; i < num_obstacles; i++) begin
                if (expired[i]) begin
                    slot_active[i] <= 1'b0;
                end
            end
            if (spawn_done) begin
                slot_active[free_idx] <= 1'b1;
            end
        end
    end

    // Scroll active slots and load the new obstacle
    always_ff @(posedge clk) begin
        if (step) begin
            for (int i = 0; i < num_obstacles; i++) begin
                if (slot_active[i]) begin
                    slot_x[i] <= slot_x[i] - map_pkg::pos_x_t'(scroll_speed);
                end
            end
            if (spawn_done) begin
                slot_x[free_idx] <= map_pkg::pos_x_t'(map_pkg::screen_width);
                slot_y[free_idx] <= new_y;
                slot_w[free_idx] <= new_width;
                slot_h[free_idx] <= new_height;
            end
        end
    end

    a_removed_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(removed_count) <= num_obstacles
    );

endmodule

`default_nettype wire

// ==== source/obstacle_view.sv ====
// Screen rectangles per obstacle slot
`default_nettype none
`timescale 1ns/1ps

module obstacle_view #(
    parameter int num_obstacles = 10
) (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  wire  [num_obstacles-1:0]                slot_active,
    input  map_pkg::pos_x_t    [num_obstacles-1:0]  slot_x,
    input  map_pkg::screen_y_t [num_obstacles-1:0]  slot_y,
    input  map_pkg::size_t     [num_obstacles-1:0]  slot_w,
    input  map_pkg::size_t     [num_obstacles-1:0]  slot_h,
    output map_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_left,
    output map_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_right,
    output map_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_up,
    output map_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_down
);

    for (genvar i = 0; i < num_obstacles; i++) begin : g_slot
        map_pkg::pos_x_t x;
        logic            visible;

        assign x       = slot_x[i];
        // Left edge has to sit on the screen
        assign visible = slot_active[i] && (x >= 0) &&
                         (x < map_pkg::pos_x_t'(map_pkg::screen_width));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                obstacle_x_left[i]  <= map_pkg::screen_x_t'(map_pkg::hidden_x);
                obstacle_x_right[i] <= map_pkg::screen_x_t'(map_pkg::hidden_x);
                obstacle_y_up[i]    <= map_pkg::screen_y_t'(map_pkg::hidden_y);
                obstacle_y_down[i]  <= map_pkg::screen_y_t'(map_pkg::hidden_y);
            end else if (visible) begin
                obstacle_x_left[i]  <= map_pkg::screen_x_t'(x);
                obstacle_x_right[i] <= map_pkg::screen_x_t'(x + map_pkg::pos_x_t'(slot_w[i]));
                obstacle_y_up[i]    <= slot_y[i];
                obstacle_y_down[i]  <= slot_y[i] + map_pkg::screen_y_t'(slot_h[i]);
            end else begin
                obstacle_x_left[i]  <= map_pkg::screen_x_t'(map_pkg::hidden_x);
                obstacle_x_right[i] <= map_pkg::screen_x_t'(map_pkg::hidden_x);
                obstacle_y_up[i]    <= map_pkg::screen_y_t'(map_pkg::hidden_y);
                obstacle_y_down[i]  <= map_pkg::screen_y_t'(map_pkg::hidden_y);
            end
        end

        a_edge_order: assert property (
            @(posedge clk) disable iff (!rst_n)
            (obstacle_x_left[i] != map_pkg::screen_x_t'(map_pkg::hidden_x)) |->
                (obstacle_x_right[i] > obstacle_x_left[i])
        );
    end

endmodule

`default_nettype wire

// ==== source/map_top.sv ====
// Obstacle map top level
`default_nettype none
`timescale 1ns/1ps

module map_top #(
    parameter int num_obstacles = 10,
    parameter int scroll_speed  = 4
) (
    input  wire                                     clk,
    input  wire                                     rst_n,
    input  map_pkg::game_mode_e                     gamemode,
    output map_pkg::score_t                         score,
    output map_pkg::screen_x_t                      displacement,
    output map_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_left,
    output map_pkg::screen_x_t [num_obstacles-1:0]  obstacle_x_right,
    output map_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_up,
    output map_pkg::screen_y_t [num_obstacles-1:0]  obstacle_y_down
);

    // Control between run_ctrl and the field
    logic            run;
    logic            clear;
    logic            spawn_req;
    logic            spawn_done;
    map_pkg::score_t removed_count;

    // Next obstacle draw
    map_pkg::size_t     new_width;
    map_pkg::size_t     new_height;
    map_pkg::size_t     new_gap;
    map_pkg::screen_y_t new_y;

    // Slot contents towards the view
    logic [num_obstacles-1:0]                  slot_active;
    map_pkg::pos_x_t    [num_obstacles-1:0]    slot_x;
    map_pkg::screen_y_t [num_obstacles-1:0]    slot_y;
    map_pkg::size_t     [num_obstacles-1:0]    slot_w;
    map_pkg::size_t     [num_obstacles-1:0]    slot_h;

    obstacle_rng rng0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .new_width  (new_width),
        .new_height (new_height),
        .new_gap    (new_gap),
        .new_y      (new_y)
    );

    run_ctrl #(.scroll_speed(scroll_speed)) ctrl0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .gamemode      (gamemode),
        .new_gap       (new_gap),
        .spawn_done    (spawn_done),
        .removed_count (removed_count),
        .run           (run),
        .clear         (clear),
        .spawn_req     (spawn_req),
        .score         (score),
        .displacement  (displacement)
    );

    obstacle_field #(
        .num_obstacles (num_obstacles),
        .scroll_speed  (scroll_speed)
    ) field0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .run           (run),
        .clear         (clear),
        .spawn_req     (spawn_req),
        .new_width     (new_width),
        .new_height    (new_height),
        .new_y         (new_y),
        .spawn_done    (spawn_done),
        .removed_count (removed_count),
        .slot_active   (slot_active),
        .slot_x        (slot_x),
        .slot_y        (slot_y),
        .slot_w        (slot_w),
        .slot_h        (slot_h)
    );

    obstacle_view #(.num_obstacles(num_obstacles)) view0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .slot_active      (slot_active),
        .slot_x           (slot_x),
        .slot_y           (slot_y),
        .slot_w           (slot_w),
        .slot_h           (slot_h),
        .obstacle_x_left  (obstacle_x_left),
        .obstacle_x_right (obstacle_x_right),
        .obstacle_y_up    (obstacle_y_up),
        .obstacle_y_down  (obstacle_y_down)
    );

endmodule

`default_nettype wire

// ==== test/tb_map.sv ====
// Obstacle map testbench
`default_nettype none
`timescale 1ns/1ps

module tb_map;

    localparam int num_obstacles   = 10;
    localparam int scroll_speed    = 4;
    localparam int clk_period      = 40;
    localparam int reset_cycles    = 4;
    localparam int scroll_cycles   = 50;
    localparam int max_pause       = 4 + 31;
    localparam int geometry_cycles = 400;
    localparam int score_cycles    = 600;
    localparam int idle_cycles     = 3;
    // Sum of all test lengths plus a margin for setup cycles
    localparam int total_cycles = reset_cycles + scroll_cycles + max_pause + geometry_cycles +
                                  score_cycles + idle_cycles + 64;

    logic                                     clk;
    logic                                     rst_n;
    map_pkg::game_mode_e                      gamemode;
    map_pkg::score_t                          score;
    map_pkg::screen_x_t                       displacement;
    map_pkg::screen_x_t [num_obstacles-1:0]   x_left;
    map_pkg::screen_x_t [num_obstacles-1:0]   x_right;
    map_pkg::screen_y_t [num_obstacles-1:0]   y_up;
    map_pkg::screen_y_t [num_obstacles-1:0]   y_down;

    int          error_count = 0;
    int          check_count = 0;
    logic [15:0] lfsr_state  = 16'd64;

    map_top #(
        .num_obstacles (num_obstacles),
        .scroll_speed  (scroll_speed)
    ) dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .gamemode         (gamemode),
        .score            (score),
        .displacement     (displacement),
        .obstacle_x_left  (x_left),
        .obstacle_x_right (x_right),
        .obstacle_y_up    (y_up),
        .obstacle_y_down  (y_down)
    );

    always #(clk_period / 2) clk = ~clk;

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value      = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %0d ns: %s (got %0d, expected %0d)", $time, msg, actual, expected);
        end
    endtask

    task automatic verify_sentinels(input string where);
        for (int i = 0; i < num_obstacles; i++) begin
            check_value(32'(x_left[i]), map_pkg::hidden_x, $sformatf("%s slot %0d left", where, i));
            check_value(32'(x_right[i]), map_pkg::hidden_x, $sformatf("%s slot %0d right", where, i));
            check_value(32'(y_up[i]), map_pkg::hidden_y, $sformatf("%s slot %0d up", where, i));
            check_value(32'(y_down[i]), map_pkg::hidden_y, $sformatf("%s slot %0d down", where, i));
        end
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic expect_reset_state();
        @(negedge clk);
        check_value(32'(score), 0, "score after reset");
        check_value(32'(displacement), 0, "displacement after reset");
        verify_sentinels("reset");
    endtask

    task automatic measure_scroll_steps();
        map_pkg::screen_x_t prev;
        map_pkg::screen_x_t step;
        @(negedge clk);
        prev     = displacement;
        gamemode = map_pkg::mode_run;
        for (int i = 0; i < scroll_cycles; i++) begin
            @(negedge clk);
            step = prev - displacement;
            check_value(32'(step), scroll_speed, "displacement step in run");
            prev = displacement;
        end
    endtask

    task automatic hold_in_pause();
        int                 pause_len;
        map_pkg::score_t    snap_score;
        map_pkg::screen_x_t snap_disp;
        logic [num_obstacles*38-1:0] snap_rect;
        draw_bits(5, pause_len);
        pause_len = pause_len + 4;
        gamemode  = map_pkg::mode_pause_a;
        // View output settles one cycle after the slots freeze
        @(negedge clk);
        @(negedge clk);
        snap_score = score;
        snap_disp  = displacement;
        snap_rect  = {x_left, x_right, y_up, y_down};
        for (int i = 0; i < pause_len; i++) begin
            if (i == pause_len / 2) begin
                gamemode = map_pkg::mode_pause_b;
            end
            @(negedge clk);
            check_value(32'(score), 32'(snap_score), "score moved in pause");
            check_value(32'(displacement), 32'(snap_disp), "displacement moved in pause");
            check_value(32'({x_left, x_right, y_up, y_down} == snap_rect), 1,
                        "rectangles moved in pause");
        end
    endtask

    task automatic scan_obstacle_geometry();
        int visible_seen;
        int w;
        int h;
        visible_seen = 0;
        gamemode     = map_pkg::mode_run;
        for (int c = 0; c < geometry_cycles; c++) begin
            @(negedge clk);
            for (int i = 0; i < num_obstacles; i++) begin
                if (int'(x_left[i]) != map_pkg::hidden_x) begin
                    visible_seen++;
                    w = int'(x_right[i]) - int'(x_left[i]);
                    h = int'(y_down[i]) - int'(y_up[i]);
                    check_value(32'(w >= map_pkg::min_width && w <= map_pkg::max_width), 1,
                                $sformatf("slot %0d width %0d out of range", i, w));
                    check_value(32'(h >= map_pkg::min_height && h <= map_pkg::max_height), 1,
                                $sformatf("slot %0d height %0d out of range", i, h));
                    check_value(32'(int'(y_up[i]) >= map_pkg::upper_bound), 1,
                                $sformatf("slot %0d above play area", i));
                    check_value(32'(int'(y_down[i]) <= map_pkg::lower_bound), 1,
                                $sformatf("slot %0d below play area", i));
                    check_value(32'(int'(x_left[i]) < map_pkg::screen_width), 1,
                                $sformatf("slot %0d left edge off screen", i));
                end
            end
        end
        check_value(32'(visible_seen > 0), 1, "no obstacle became visible");
    endtask

    task automatic track_score_growth();
        map_pkg::score_t last;
        last = score;
        for (int c = 0; c < score_cycles; c++) begin
            @(negedge clk);
            check_value(32'(score >= last), 1, "score decreased");
            last = score;
        end
        check_value(32'(score > 0), 1, "score still zero after run");
    endtask

    task automatic return_to_idle();
        gamemode = map_pkg::mode_idle;
        repeat (idle_cycles) @(negedge clk);
        check_value(32'(score), 0, "score after idle");
        verify_sentinels("idle");
    endtask

    // ============================================================
    // Main sequence and watchdog
    // ============================================================
    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        gamemode = map_pkg::mode_idle;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        expect_reset_state();
        measure_scroll_steps();
        hold_in_pause();
        scan_obstacle_geometry();
        track_score_growth();
        return_to_idle();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(total_cycles * clk_period);
        $display("Watchdog expired: tests did not finish within %0d cycles", total_cycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
source/map_pkg.sv
source/obstacle_rng.sv
source/run_ctrl.sv
source/obstacle_field.sv
source/obstacle_view.sv
source/map_top.sv
test/tb_map.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the obstacle map testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_map -f filelist.f -o tb_map_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/tb_map_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1
